// File: Bender.yml
package:
  name: mem_ctrl

sources:
  # RTL in compile order
  - files:
      - hw/mem_pkg.sv
      - hw/mem_cycle_decode.sv
      - hw/mem_sequencer.sv
      - hw/mem_strobe_gen.sv
      - hw/mem_ctrl.sv
  # Testbench, top module mem_ctrl_tb
  - target: simulation
    files:
      - sim/mem_ctrl_tb.sv

// File: hw/mem_ctrl.sv
// ================================================
// Top of the memory cycle controller, single bank
// ================================================
`default_nettype none

module mem_ctrl import mem_pkg::*; (
	input  wire logic                   sys_clk,
	input  wire logic                   resetl,
	input  wire logic                   mreq,
	input  wire logic                   rw,
	input  wire logic [ADDR_LO_W-1:0]   addr,
	input  wire mem_width_e             mw,
	input  wire logic                   sel_dram,
	input  wire logic                   sel_rom,
	input  wire logic                   match,
	input  wire logic                   refreq,
	input  wire logic [SPD_W-1:0]       dspd,
	input  wire logic [SPD_W-1:0]       romspd,
	input  wire logic [SPD_W-1:0]       iospd,
	input  wire logic                   bigend,
	input  wire logic                   waitl,
	output logic                        ack,
	output logic                        refack,
	output logic                        rasl,
	output logic                        casl,
	output logic                        romcsl,
	output logic                        iocsl,
	output logic                        newrow,
	output logic                        oel,
	output logic [DATA_BYTES-1:0]       wel
);

	// Sequencer to decoder
	logic                  accept;
	// Decoder to sequencer and strobes
	cycle_kind_e           cycle_kind;
	logic                  read;
	logic [DATA_BYTES-1:0] byte_mask;
	// Sequencer to strobes
	seq_state_e            state;
	logic                  dev_phase;

	mem_cycle_decode u_decode (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.accept     (accept),
		.mreq       (mreq),
		.rw         (rw),
		.addr       (addr),
		.mw         (mw),
		.sel_dram   (sel_dram),
		.sel_rom    (sel_rom),
		.match      (match),
		.refreq     (refreq),
		.bigend     (bigend),
		.cycle_kind (cycle_kind),
		.read       (read),
		.byte_mask  (byte_mask)
	);

	mem_sequencer u_seq (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.mreq       (mreq),
		.refreq     (refreq),
		.cycle_kind (cycle_kind),
		.dspd       (dspd),
		.romspd     (romspd),
		.iospd      (iospd),
		.waitl      (waitl),
		.accept     (accept),
		.ack        (ack),
		.state      (state),
		.dev_phase  (dev_phase)
	);

	mem_strobe_gen u_strobe (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.state      (state),
		.dev_phase  (dev_phase),
		.cycle_kind (cycle_kind),
		.read       (read),
		.byte_mask  (byte_mask),
		.rasl       (rasl),
		.casl       (casl),
		.romcsl     (romcsl),
		.iocsl      (iocsl),
		.newrow     (newrow),
		.refack     (refack),
		.oel        (oel),
		.wel        (wel)
	);

endmodule

`default_nettype wire

// File: hw/mem_cycle_decode.sv
// ================================================
// Kind is combinational; direction and lanes are
// captured only on the sequencer's accept pulse
// ================================================
`default_nettype none

module mem_cycle_decode import mem_pkg::*; (
	input  wire logic                   sys_clk,
	input  wire logic                   resetl,
	input  wire logic                   accept,
	input  wire logic                   mreq,
	input  wire logic                   rw,
	input  wire logic [ADDR_LO_W-1:0]   addr,
	input  wire mem_width_e             mw,
	input  wire logic                   sel_dram,
	input  wire logic                   sel_rom,
	input  wire logic                   match,
	input  wire logic                   refreq,
	input  wire logic                   bigend,
	output cycle_kind_e                 cycle_kind,
	output logic                        read,
	output logic [DATA_BYTES-1:0]       byte_mask
);

	// Run of lanes for the width, before placement
	logic [DATA_BYTES-1:0] lane_run;
	// Keeps only the address bits above the width
	logic [ADDR_LO_W-1:0]  align;
	logic [DATA_BYTES-1:0] le_mask;
	logic [DATA_BYTES-1:0] be_mask;
	logic [DATA_BYTES-1:0] mask_next;

	// Request class, refresh first, then DRAM, then ROM
	always_comb begin
		if (refreq)
			cycle_kind = CYC_REFRESH;
		else if (!mreq)
			cycle_kind = CYC_NONE;
		else if (sel_dram)
			cycle_kind = match ? CYC_PAGE_HIT : CYC_PAGE_MISS;
		else if (sel_rom)
			cycle_kind = CYC_ROM;
		else
			// Nothing selected means the external I/O space
			cycle_kind = CYC_IO;
	end

	// Byte lanes from width and low address
	always_comb begin
		case (mw)
			WIDTH_8: begin
				lane_run = DATA_BYTES'(8'h01);
				align    = ADDR_LO_W'(3'b111);
			end
			WIDTH_16: begin
				lane_run = DATA_BYTES'(8'h03);
				align    = ADDR_LO_W'(3'b110);
			end
			WIDTH_32: begin
				lane_run = DATA_BYTES'(8'h0f);
				align    = ADDR_LO_W'(3'b100);
			end
			default: begin
				lane_run = '1;
				align    = '0;
			end
		endcase
		// Aligned group that holds addr
		le_mask = lane_run << (addr & align);
		// Big-endian swaps lane i with lane 7-i
		for (int i = 0; i < DATA_BYTES; i++)
			be_mask[i] = le_mask[DATA_BYTES-1-i];
		mask_next = bigend ? be_mask : le_mask;
	end

	// Capture on accept, held for the whole cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			read      <= 1'b0;
			byte_mask <= '0;
		end else if (accept) begin
			// Refresh moves no data, so no lanes and no read
			read      <= rw & (cycle_kind != CYC_REFRESH);
			byte_mask <= (cycle_kind == CYC_REFRESH) ? '0 : mask_next;
		end
	end

	// A live request must always map to a real class
	a_kind_valid: assert property (@(posedge sys_clk) disable iff (!resetl)
		(mreq || refreq) |-> (cycle_kind != CYC_NONE));

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
// ================================================
// Single DRAM bank, 64-bit data path, 8 byte lanes
// Wait tables assume a 4-bit counter, max 15 waits
// ================================================
`default_nettype none

package mem_pkg;

	// Data path geometry
	localparam int DATA_BYTES = 8;
	// Low address bits that pick a byte lane
	localparam int ADDR_LO_W = 3;

	// Each speed setting is a 2-bit code
	localparam int SPD_W = 2;
	// Wait-state counter width
	localparam int WAIT_W = 4;

	// Transfer width, lanes covered = 1 << code
	typedef enum logic [1:0] {
		WIDTH_8  = 2'd0,
		WIDTH_16 = 2'd1,
		WIDTH_32 = 2'd2,
		WIDTH_64 = 2'd3
	} mem_width_e;

	// Request class, fixed at acceptance
	typedef enum logic [2:0] {
		CYC_NONE      = 3'd0,
		CYC_REFRESH   = 3'd1,
		CYC_PAGE_HIT  = 3'd2,
		CYC_PAGE_MISS = 3'd3,
		CYC_ROM       = 3'd4,
		CYC_IO        = 3'd5
	} cycle_kind_e;

	// Sequencer states
	typedef enum logic [2:0] {
		// Waiting for a request, ack high
		ST_IDLE      = 3'd0,
		// RAS precharge, shared by page miss and refresh
		ST_PRECHARGE = 3'd1,
		// Row strobe before CAS on a page miss
		ST_RAS       = 3'd2,
		// Column access, two cycles
		ST_CAS       = 3'd3,
		// RAS-only refresh pulse
		ST_REF_RAS   = 3'd4,
		// ROM or external I/O access
		ST_DEV       = 3'd5
	} seq_state_e;

	// ROM wait states indexed by romspd, entry 0 slowest
	localparam logic [3:0][WAIT_W-1:0] ROM_WAITS = {
		4'd2, 4'd3, 4'd5, 4'd7
	};

	// I/O (DSP) wait states indexed by iospd, entry 0 slowest
	localparam logic [3:0][WAIT_W-1:0] IO_WAITS = {
		4'd1, 4'd3, 4'd7, 4'd15
	};

endpackage

`default_nettype wire

// File: hw/mem_sequencer.sv
// ================================================
// One cycle per request, no pipelining; waitl is
// registered once before it can end a device cycle
// ================================================
`default_nettype none

module mem_sequencer import mem_pkg::*; (
	input  wire logic               sys_clk,
	input  wire logic               resetl,
	input  wire logic               mreq,
	input  wire logic               refreq,
	input  wire cycle_kind_e        cycle_kind,
	input  wire logic [SPD_W-1:0]   dspd,
	input  wire logic [SPD_W-1:0]   romspd,
	input  wire logic [SPD_W-1:0]   iospd,
	input  wire logic               waitl,
	output logic                    accept,
	output logic                    ack,
	output seq_state_e              state,
	output logic                    dev_phase
);

	// Remaining cycles of the current DRAM phase, minus one
	logic [SPD_W-1:0]  phase_cnt;
	logic [WAIT_W-1:0] wait_cnt;
	// Set for a refresh, steers the end of precharge
	logic              is_ref;
	logic              waitl_q;
	logic              dev_start;
	logic              phase_done;
	logic              wait_done;

	// Ack is simply the idle state
	assign ack    = (state == ST_IDLE);
	assign accept = ack & (mreq | refreq);

	// Device cycle starts on a ROM or I/O acceptance
	assign dev_start  = accept & ((cycle_kind == CYC_ROM) | (cycle_kind == CYC_IO));
	assign phase_done = (phase_cnt == '0);
	// Device ends once the waits are spent and the pin is released
	assign wait_done  = (wait_cnt == '0) & waitl_q;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state     <= ST_IDLE;
			phase_cnt <= '0;
			is_ref    <= 1'b0;
			dev_phase <= 1'b0;
			waitl_q   <= 1'b1;
		end else begin
			// High only in the first ST_DEV cycle
			dev_phase <= dev_start;
			waitl_q   <= waitl;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						is_ref <= (cycle_kind == CYC_REFRESH);
						case (cycle_kind)
							CYC_REFRESH, CYC_PAGE_MISS: begin
								// Precharge stretches to dspd+1 cycles
								state     <= ST_PRECHARGE;
								phase_cnt <= dspd;
							end
							CYC_PAGE_HIT: begin
								// Row still open, straight to two CAS cycles
								state     <= ST_CAS;
								phase_cnt <= SPD_W'(1);
							end
							CYC_ROM, CYC_IO:
								state <= ST_DEV;
							default:
								state <= ST_IDLE;
						endcase
					end
				end
				ST_PRECHARGE: begin
					if (!phase_done) begin
						phase_cnt <= phase_cnt - SPD_W'(1);
					end else if (is_ref) begin
						// Refresh RAS also lasts dspd+1 cycles
						state     <= ST_REF_RAS;
						phase_cnt <= dspd;
					end else begin
						state <= ST_RAS;
					end
				end
				ST_RAS: begin
					// Single row strobe cycle then column access
					state     <= ST_CAS;
					phase_cnt <= SPD_W'(1);
				end
				ST_CAS, ST_REF_RAS: begin
					if (phase_done)
						state <= ST_IDLE;
					else
						phase_cnt <= phase_cnt - SPD_W'(1);
				end
				ST_DEV: begin
					if (wait_done)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Wait counter, loaded from the speed table at acceptance
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			wait_cnt <= '0;
		end else if (dev_start) begin
			if (cycle_kind == CYC_ROM)
				wait_cnt <= ROM_WAITS[romspd];
			else
				wait_cnt <= IO_WAITS[iospd];
		end else if (state == ST_DEV && !dev_phase && wait_cnt != '0) begin
			// First device cycle holds, giving W+2 cycles overall
			wait_cnt <= wait_cnt - WAIT_W'(1);
		end
	end

	// Accept is taken from idle and always leaves it
	a_accept_idle: assert property (@(posedge sys_clk) disable iff (!resetl)
		accept |-> (state == ST_IDLE) ##1 (state != ST_IDLE));

	// The counter only climbs right after a device acceptance
	a_wait_load: assert property (@(posedge sys_clk) disable iff (!resetl)
		(wait_cnt > $past(wait_cnt)) |-> $past(dev_start));

endmodule

`default_nettype wire

// File: hw/mem_strobe_gen.sv
// ================================================
// Strobes decode straight from sequencer state
// ================================================
`default_nettype none

module mem_strobe_gen import mem_pkg::*; (
	input  wire logic                   sys_clk,
	input  wire logic                   resetl,
	input  wire seq_state_e             state,
	input  wire logic                   dev_phase,
	input  wire cycle_kind_e            cycle_kind,
	input  wire logic                   read,
	input  wire logic [DATA_BYTES-1:0]  byte_mask,
	output logic                        rasl,
	output logic                        casl,
	output logic                        romcsl,
	output logic                        iocsl,
	output logic                        newrow,
	output logic                        refack,
	output logic                        oel,
	output logic [DATA_BYTES-1:0]       wel
);

	// Class of the cycle in flight, frozen when idle ends
	cycle_kind_e kind_q;
	// Data phase where output or write enables may assert
	logic        xfer_active;
	logic        ref_cycle;

	// Tracks the live class while idle, so it holds the accepted one
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			kind_q <= CYC_NONE;
		else if (state == ST_IDLE)
			kind_q <= cycle_kind;
	end

	assign ref_cycle = (kind_q == CYC_REFRESH);

	// RAS held across row strobe, column access and refresh
	assign rasl = !((state == ST_RAS) || (state == ST_CAS) || (state == ST_REF_RAS));
	assign casl = !(state == ST_CAS);

	// Only one device select, picked by the held class
	assign romcsl = !((state == ST_DEV) && (kind_q == CYC_ROM));
	assign iocsl  = !((state == ST_DEV) && (kind_q == CYC_IO));

	// Row address change flagged through precharge
	assign newrow = (state == ST_PRECHARGE);
	assign refack = ref_cycle && ((state == ST_PRECHARGE) || (state == ST_REF_RAS));

	// Device data waits one cycle for the select to settle
	assign xfer_active = (state == ST_CAS) || ((state == ST_DEV) && !dev_phase);

	// Reads drive oel, writes drop the selected lanes
	assign oel = !(xfer_active && read);
	assign wel = ~({DATA_BYTES{xfer_active && !read}} & byte_mask);

	// Bus direction never overlaps on the data lanes
	a_oe_we_excl: assert property (@(posedge sys_clk) disable iff (!resetl)
		!(!oel && (wel != '1)));

	// ROM and I/O selects are mutually exclusive
	a_cs_excl: assert property (@(posedge sys_clk) disable iff (!resetl)
		!(!romcsl && !iocsl));

endmodule

`default_nettype wire

// File: sim/mem_ctrl_tb.sv
// ================================================
// Checks every cycle kind against the timing rules
// Waits for ack rising; a cycle watchdog bounds it
// ================================================
`default_nettype none

module mem_ctrl_tb import mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_ENT = 29;
	// Span kinds, also the table's cycle kinds
	localparam int K_REF = 0;
	localparam int K_HIT = 1;
	localparam int K_MISS = 2;
	localparam int K_ROM = 3;
	localparam int K_IO = 4;

	logic                  sys_clk;
	logic                  resetl;
	logic                  mreq;
	logic                  rw;
	logic [ADDR_LO_W-1:0]  addr;
	mem_width_e            mw;
	logic                  sel_dram;
	logic                  sel_rom;
	logic                  match;
	logic                  refreq;
	logic [SPD_W-1:0]      dspd;
	logic [SPD_W-1:0]      romspd;
	logic [SPD_W-1:0]      iospd;
	logic                  bigend;
	logic                  waitl;
	logic                  ack;
	logic                  refack;
	logic                  rasl;
	logic                  casl;
	logic                  romcsl;
	logic                  iocsl;
	logic                  newrow;
	logic                  oel;
	logic [DATA_BYTES-1:0] wel;

	// Stimulus table, one request per entry
	int t_kind[N_ENT];
	bit t_ref[N_ENT];
	bit t_rw[N_ENT];
	int t_addr[N_ENT];
	int t_mw[N_ENT];
	bit t_be[N_ENT];
	int t_dspd[N_ENT];
	int t_romspd[N_ENT];
	int t_iospd[N_ENT];
	int t_wait[N_ENT];
	// Expected ack-low counts, refresh span apart
	int t_exp_cnt[N_ENT];
	int t_exp_ref[N_ENT];
	logic [DATA_BYTES-1:0] t_exp_mask[N_ENT];

	// Wait states per speed code
	int rom_w[4] = '{7, 5, 3, 2};
	int io_w[4] = '{15, 7, 3, 1};
	string kind_names[5] = '{"refresh", "page hit", "page miss", "rom", "io"};

	int seed = 17951;
	int err_cnt = 0;
	int limit = 0;
	int cycle_cnt = 0;
	int spans_done = 0;
	bit in_span = 1'b0;
	// Per-span monitor results
	int m_cnt;
	int m_new;
	int m_ras;
	int m_cas;
	int m_ref;
	int m_rom;
	int m_io;
	int m_oe;
	int m_fras;
	int m_fcas;
	int m_fref;
	logic [DATA_BYTES-1:0] m_lanes;

	mem_ctrl u_dut (
		.sys_clk  (sys_clk),
		.resetl   (resetl),
		.mreq     (mreq),
		.rw       (rw),
		.addr     (addr),
		.mw       (mw),
		.sel_dram (sel_dram),
		.sel_rom  (sel_rom),
		.match    (match),
		.refreq   (refreq),
		.dspd     (dspd),
		.romspd   (romspd),
		.iospd    (iospd),
		.bigend   (bigend),
		.waitl    (waitl),
		.ack      (ack),
		.refack   (refack),
		.rasl     (rasl),
		.casl     (casl),
		.romcsl   (romcsl),
		.iocsl    (iocsl),
		.newrow   (newrow),
		.oel      (oel),
		.wel      (wel)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			err_cnt++;
		end
	endtask

	// Aligned lane group of the width, mirrored for big-endian
	function automatic logic [DATA_BYTES-1:0] lane_mask(input int w, input int a, input bit be);
		int lanes;
		int base;
		logic [DATA_BYTES-1:0] m;
		logic [DATA_BYTES-1:0] r;
		lanes = 1 << w;
		base = (a / lanes) * lanes;
		m = '0;
		for (int i = 0; i < DATA_BYTES; i++)
			m[i] = (i >= base) && (i < base + lanes);
		r = m;
		if (be)
			for (int i = 0; i < DATA_BYTES; i++)
				r[i] = m[DATA_BYTES-1-i];
		return r;
	endfunction

	// Ack-low length; devices end at counter zero with waitl high
	function automatic int expected_cycles(input int kind, input int d, input int w, input int n);
		case (kind)
			K_HIT: return 2;
			K_MISS: return d + 4;
			K_REF: return 2 * d + 2;
			default: return (w > n) ? w + 2 : n + 2;
		endcase
	endfunction

	task automatic add_entry(input int n, input int kind, input bit rf, input bit rd,
			input int d, input int rs, input int ios, input int wn);
		t_kind[n] = kind;
		t_ref[n] = rf;
		t_rw[n] = rd;
		t_dspd[n] = d;
		t_romspd[n] = rs;
		t_iospd[n] = ios;
		t_wait[n] = wn;
		// Random fill-ins, writes override width and endianness
		t_addr[n] = $random(seed) & 7;
		t_mw[n] = $random(seed) & 3;
		t_be[n] = $random(seed) & 1;
	endtask

	task automatic build_table();
		int n;
		int w;
		n = 0;
		// Page-hit then page-miss reads at every DRAM speed
		for (int k = K_HIT; k <= K_MISS; k++)
			for (int d = 0; d < 4; d++) begin
				add_entry(n, k, 0, 1, d, 0, 0, 0);
				n++;
			end
		// Writes of every width with both byte orders
		for (int mwi = 0; mwi < 4; mwi++)
			for (int b = 0; b < 2; b++) begin
				add_entry(n, (n % 2) ? K_HIT : K_MISS, 0, 0, $random(seed) & 3, 0, 0, 0);
				t_mw[n] = mwi;
				t_be[n] = b;
				n++;
			end
		// Refresh racing a held request
		add_entry(n, K_MISS, 1, 0, 1, 0, 0, 0);
		n++;
		add_entry(n, K_HIT, 1, 1, 3, 0, 0, 0);
		n++;
		for (int s = 0; s < 4; s++) begin
			add_entry(n, K_ROM, 0, s % 2, 0, s, 0, 0);
			n++;
			add_entry(n, K_IO, 0, (s + 1) % 2, 0, 0, s, 0);
			n++;
		end
		// waitl low past the counter, and once inside it
		add_entry(n, K_IO, 0, 1, 0, 0, 3, 5);
		add_entry(n + 1, K_IO, 0, 0, 0, 0, 2, 2);
		add_entry(n + 2, K_IO, 0, 1, 0, 0, 1, 9);
		limit = 20;
		for (int i = 0; i < N_ENT; i++) begin
			w = (t_kind[i] == K_ROM) ? rom_w[t_romspd[i]] : io_w[t_iospd[i]];
			t_exp_cnt[i] = expected_cycles(t_kind[i], t_dspd[i], w, t_wait[i]);
			t_exp_ref[i] = t_ref[i] ? expected_cycles(K_REF, t_dspd[i], 0, 0) : 0;
			t_exp_mask[i] = lane_mask(t_mw[i], t_addr[i], t_be[i]);
			limit += t_exp_cnt[i] + t_exp_ref[i] + t_wait[i] + 6;
		end
	endtask

	// Samples mid-cycle; a span is the run of ack-low cycles
	always @(negedge sys_clk) begin
		if (resetl && !ack) begin
			if (!in_span) begin
				in_span = 1'b1;
				m_cnt = 0;
				m_new = 0;
				m_ras = 0;
				m_cas = 0;
				m_ref = 0;
				m_rom = 0;
				m_io = 0;
				m_oe = 0;
				m_fras = 0;
				m_fcas = 0;
				m_fref = 0;
				m_lanes = '0;
			end
			m_cnt++;
			m_new += newrow;
			m_ras += !rasl;
			m_cas += !casl;
			m_ref += refack;
			m_rom += !romcsl;
			m_io += !iocsl;
			m_oe += !oel;
			if (!rasl && m_fras == 0)
				m_fras = m_cnt;
			if (!casl && m_fcas == 0)
				m_fcas = m_cnt;
			if (refack && m_fref == 0)
				m_fref = m_cnt;
			m_lanes |= ~wel;
		end else if (in_span) begin
			in_span = 1'b0;
			spans_done++;
		end
	end

	task automatic verify_span(input int kind, input bit rd, input int d, input int cnt,
			input logic [DATA_BYTES-1:0] mask);
		bit dram;
		int e_ras;
		int e_fras;
		dram = (kind == K_HIT) || (kind == K_MISS);
		e_ras = (kind == K_HIT) ? 2 : (kind == K_MISS) ? 3 : (kind == K_REF) ? d + 1 : 0;
		e_fras = (kind == K_HIT) ? 1 : (kind == K_MISS || kind == K_REF) ? d + 2 : 0;
		compare_value("ack_low_cycles", m_cnt, cnt);
		compare_value("newrow_cycles", m_new, (kind == K_MISS || kind == K_REF) ? d + 1 : 0);
		compare_value("rasl_cycles", m_ras, e_ras);
		compare_value("rasl_first", m_fras, e_fras);
		compare_value("casl_cycles", m_cas, dram ? 2 : 0);
		compare_value("casl_first", m_fcas, (kind == K_HIT) ? 1 : (kind == K_MISS) ? d + 3 : 0);
		compare_value("refack_cycles", m_ref, (kind == K_REF) ? cnt : 0);
		compare_value("refack_first", m_fref, (kind == K_REF) ? 1 : 0);
		compare_value("romcsl_cycles", m_rom, (kind == K_ROM) ? cnt : 0);
		compare_value("iocsl_cycles", m_io, (kind == K_IO) ? cnt : 0);
		// Devices hold the data phase back one cycle
		compare_value("oel_cycles", m_oe, (!rd || kind == K_REF) ? 0 : dram ? 2 : cnt - 1);
		compare_value("wel_lanes", m_lanes, (rd || kind == K_REF) ? '0 : mask);
	endtask

	task automatic run_entry(input int i);
		int errs_before;
		int target;
		errs_before = err_cnt;
		target = spans_done;
		@(posedge sys_clk);
		mreq <= 1'b1;
		refreq <= t_ref[i];
		rw <= t_rw[i];
		addr <= ADDR_LO_W'(t_addr[i]);
		mw <= mem_width_e'(t_mw[i]);
		sel_dram <= (t_kind[i] == K_HIT) || (t_kind[i] == K_MISS);
		sel_rom <= (t_kind[i] == K_ROM);
		match <= (t_kind[i] == K_HIT);
		bigend <= t_be[i];
		dspd <= SPD_W'(t_dspd[i]);
		romspd <= SPD_W'(t_romspd[i]);
		iospd <= SPD_W'(t_iospd[i]);
		waitl <= 1'b1;
		// Acceptance edge, ack is high throughout the cycle before
		@(posedge sys_clk);
		refreq <= 1'b0;
		if (!t_ref[i])
			mreq <= 1'b0;
		if (t_wait[i] > 0) begin
			waitl <= 1'b0;
			repeat (t_wait[i]) @(posedge sys_clk);
			waitl <= 1'b1;
		end
		if (t_ref[i]) begin
			wait (spans_done == target + 1);
			verify_span(K_REF, 1'b0, t_dspd[i], t_exp_ref[i], '0);
			target++;
			// Held request goes in on the next edge
			@(posedge sys_clk);
			mreq <= 1'b0;
		end
		wait (spans_done == target + 1);
		verify_span(t_kind[i], t_rw[i], t_dspd[i], t_exp_cnt[i], t_exp_mask[i]);
		$display("test %0d %s%s %s: %0d cycles, %s", i + 1, t_ref[i] ? "refresh then " : "",
			kind_names[t_kind[i]], t_rw[i] ? "read" : "write", m_cnt,
			(err_cnt == errs_before) ? "ok" : "errors");
	endtask

	// Watchdog, limit set from the table
	initial begin
		wait (limit > 0);
		while (cycle_cnt < limit) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", limit);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		resetl = 1'b0;
		mreq = 1'b0;
		rw = 1'b0;
		addr = '0;
		mw = WIDTH_8;
		sel_dram = 1'b0;
		sel_rom = 1'b0;
		match = 1'b0;
		refreq = 1'b0;
		dspd = '0;
		romspd = '0;
		iospd = '0;
		bigend = 1'b0;
		waitl = 1'b1;
		build_table();
		repeat (2) @(posedge sys_clk);
		resetl <= 1'b1;
		@(negedge sys_clk);
		compare_value("ack", ack, 1);
		compare_value("rasl_casl_romcsl_iocsl_oel", {rasl, casl, romcsl, iocsl, oel}, 5'h1f);
		compare_value("wel", wel, 8'hff);
		compare_value("refack", refack, 0);
		compare_value("newrow", newrow, 0);
		$display("test 0 reset: %s", (err_cnt == 0) ? "ok" : "errors");
		for (int i = 0; i < N_ENT; i++)
			run_entry(i);
		$display("tests run %0d, failed checks %0d", N_ENT + 1, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/mem_pkg.sv
hw/mem_cycle_decode.sv
hw/mem_sequencer.sv
hw/mem_strobe_gen.sv
hw/mem_ctrl.sv
sim/mem_ctrl_tb.sv
